// File: logic/uart_tx_cfg.svh
/* uart tx engine widths and defaults */
`ifndef UART_TX_CFG_SVH
`define UART_TX_CFG_SVH

// ==========================================================
// register field widths
// ==========================================================

// clock divider field, cycles per oversampling tick
`define UART_TX_CLKDIV_W 12

// oversampling field, ticks per bit
`define UART_TX_OS_W 4

// widest data word the fifo can hold
`define UART_TX_DATA_W 10

// idle bits inserted between back to back frames
`define UART_TX_INTERVAL_W 4

// ==========================================================
// defaults
// ==========================================================

// data length used for any code outside 7..10
`define UART_TX_DEFAULT_DATA_BITS 8

`endif

// File: logic/uart_tx_cfg_pkg.sv
/* uart tx configuration types */
`default_nettype none

`include "uart_tx_cfg.svh"

package uart_tx_cfg_pkg;

	// register map fields
	typedef logic [`UART_TX_CLKDIV_W-1:0] clkdiv_t;
	typedef logic [`UART_TX_OS_W-1:0] os_t;
	typedef logic [3:0] data_bits_t;
	typedef logic [1:0] stop_bits_t;
	typedef logic [`UART_TX_INTERVAL_W-1:0] interval_t;

	// parity bit source
	typedef enum logic [1:0]
	{
		PAR_EVEN = 2'd0,
		PAR_ODD  = 2'd1,
		PAR_ZERO = 2'd2,
		PAR_ONE  = 2'd3
	} parity_mode_t;

	// effective data length from the raw code
	// legal codes pass, everything else falls back
	function automatic data_bits_t eff_data_bits(input data_bits_t code);
		if ((code >= 4'd7) && (code <= 4'd10))
			return code;
		else
			return data_bits_t'(`UART_TX_DEFAULT_DATA_BITS);
	endfunction

endpackage

`default_nettype wire

// File: logic/uart_tx_fsm_pkg.sv
/* uart tx frame state types */
`default_nettype none

`include "uart_tx_cfg.svh"

package uart_tx_fsm_pkg;

	// frame states, one-hot
	typedef enum logic [6:0]
	{
		TX_IDLE     = 7'b0000001,
		TX_START    = 7'b0000010,
		TX_DATA     = 7'b0000100,
		TX_PARITY   = 7'b0001000,
		TX_STOP     = 7'b0010000,
		TX_INTERVAL = 7'b0100000,
		TX_END      = 7'b1000000
	} tx_state_t;

	// index of the bit inside data, stop or interval run
	typedef logic [3:0] bit_idx_t;

	// captured data word, upper bits zero when shorter
	typedef logic [`UART_TX_DATA_W-1:0] tx_word_t;

endpackage

`default_nettype wire

// File: logic/uart_tx_baud.sv
/* uart tx bit timing */
`default_nettype none

module uart_tx_baud
	import uart_tx_cfg_pkg::*;
(
	input wire pe_clk,
	input wire pe_rstn,
	input wire baud_run,
	input wire clkdiv_t clkdiv,
	input wire os_t oversampling,
	output logic bit_end
);

clkdiv_t div_cnt;
os_t os_cnt;
clkdiv_t div_last;
os_t os_last;
logic div_end;
logic os_end;

// zero in a field behaves like one
assign div_last = (clkdiv == '0) ? '0 : clkdiv - clkdiv_t'(1);
assign os_last = (oversampling == '0) ? '0 : oversampling - os_t'(1);

assign div_end = (div_cnt == div_last);
assign os_end = (os_cnt == os_last);

// last cycle of the last tick
assign bit_end = baud_run && div_end && os_end;

// ==========================================================
// divider and tick counters
// ==========================================================

always_ff @(posedge pe_clk or negedge pe_rstn)
begin
	if (!pe_rstn)
	begin
		div_cnt <= '0;
		os_cnt <= '0;
	end
	// parked at zero so the next bit starts aligned
	else if (!baud_run)
	begin
		div_cnt <= '0;
		os_cnt <= '0;
	end
	else if (div_end)
	begin
		div_cnt <= '0;
		// wrap with the bit
		os_cnt <= os_end ? '0 : os_cnt + os_t'(1);
	end
	else
		div_cnt <= div_cnt + clkdiv_t'(1);
end

endmodule

`default_nettype wire

// File: logic/uart_tx_ctrl.sv
/* uart tx frame controller */
`default_nettype none

module uart_tx_ctrl
	import uart_tx_cfg_pkg::*, uart_tx_fsm_pkg::*;
(
	input wire pe_clk,
	input wire pe_rstn,
	input wire tx_enable,
	input wire tx_clr,
	input wire bit_end,
	input wire fifo_empty,
	input wire data_bits_t data_bits,
	input wire parity_en,
	input wire stop_bits_t stop_bits,
	input wire interval_t interval_bits,
	output logic baud_run,
	output logic fifo_re,
	output logic bit_start,
	output tx_state_t next_state,
	output bit_idx_t next_idx,
	output logic line_release,
	output logic tx_done
);

tx_state_t cur_state;
bit_idx_t bit_idx;
data_bits_t data_len;
bit_idx_t data_last_idx;
bit_idx_t stop_last_idx;
logic run_st;
logic run_nxt;
logic data_last;
logic stop_last;
logic intv_last;

// ==========================================================
// bit run limits
// ==========================================================

assign data_len = eff_data_bits(data_bits);
assign data_last_idx = data_len - 4'd1;

// stop code 0 means a single stop bit
assign stop_last_idx = (stop_bits == 2'd0) ? 4'd0 : {2'b00, stop_bits - 2'd1};

assign data_last = (bit_idx == data_last_idx);
assign stop_last = (bit_idx == stop_last_idx);
// only reached with a nonzero interval
assign intv_last = (bit_idx == interval_bits - 4'd1);

// states that occupy the line for a bit time
assign run_st = cur_state inside {TX_START, TX_DATA, TX_PARITY, TX_STOP, TX_INTERVAL};
assign run_nxt = next_state inside {TX_START, TX_DATA, TX_PARITY, TX_STOP, TX_INTERVAL};

// ==========================================================
// state register and transitions
// ==========================================================

always_ff @(posedge pe_clk or negedge pe_rstn)
begin
	if (!pe_rstn)
		cur_state <= TX_IDLE;
	else
		cur_state <= next_state;
end

always_comb
begin
	next_state = cur_state;
	// clear wins in every state
	if (tx_clr)
		next_state = TX_IDLE;
	else
	begin
		case (cur_state)
		TX_IDLE:
			if (tx_enable)
				next_state = TX_START;
		TX_START:
			if (bit_end)
				next_state = TX_DATA;
		TX_DATA:
			if (bit_end && data_last)
				next_state = parity_en ? TX_PARITY : TX_STOP;
		TX_PARITY:
			if (bit_end)
				next_state = TX_STOP;
		TX_STOP:
			if (bit_end && stop_last)
			begin
				// nothing left, release the line
				if (fifo_empty)
					next_state = TX_END;
				else if (interval_bits != '0)
					next_state = TX_INTERVAL;
				else
					next_state = TX_START;
			end
		TX_INTERVAL:
			if (bit_end && intv_last)
				next_state = fifo_empty ? TX_END : TX_START;
		TX_END:
			next_state = TX_IDLE;
		default:
			next_state = TX_IDLE;
		endcase
	end
end

// ==========================================================
// bit index, restarts on every state change
// ==========================================================

always_comb
begin
	next_idx = bit_idx;
	if (tx_clr || !run_st)
		next_idx = '0;
	else if (bit_end)
		next_idx = (next_state == cur_state) ? bit_idx + 4'd1 : '0;
end

always_ff @(posedge pe_clk or negedge pe_rstn)
begin
	if (!pe_rstn)
		bit_idx <= '0;
	else
		bit_idx <= next_idx;
end

// ==========================================================
// strobes to timing base and datapath
// ==========================================================

// counters stop in the same cycle as the clear
assign baud_run = run_st && !tx_clr;

// new bit on the line after the next edge
assign bit_start = run_nxt && ((cur_state == TX_IDLE) || bit_end);

assign line_release = bit_end && (next_state == TX_END);

// one read per frame, first cycle of the start bit
// end pulse as the state leaves TX_END
always_ff @(posedge pe_clk or negedge pe_rstn)
begin
	if (!pe_rstn)
	begin
		fifo_re <= 1'b0;
		tx_done <= 1'b0;
	end
	else
	begin
		fifo_re <= (next_state == TX_START) && (cur_state != TX_START);
		tx_done <= (cur_state == TX_END) && !tx_clr;
	end
end

endmodule

`default_nettype wire

// File: logic/uart_tx_serializer.sv
/* uart tx data path and line drive */
`default_nettype none

`include "uart_tx_cfg.svh"

module uart_tx_serializer
	import uart_tx_cfg_pkg::*, uart_tx_fsm_pkg::*;
(
	input wire pe_clk,
	input wire pe_rstn,
	input wire fifo_re,
	input wire tx_word_t fifo_data,
	input wire data_bits_t data_bits,
	input wire parity_mode_t parity,
	input wire bit_start,
	input wire tx_state_t next_state,
	input wire bit_idx_t next_idx,
	input wire line_release,
	input wire tx_clr,
	output logic uart_tx,
	output logic uart_tx_oen
);

data_bits_t data_len;
tx_word_t word_trunc;
tx_word_t word_q;
tx_word_t word_src;
logic par_calc;
logic par_q;

// ==========================================================
// capture and parity
// ==========================================================

assign data_len = eff_data_bits(data_bits);

// zero the bits above the data length
always_comb
begin
	for (int i = 0; i < `UART_TX_DATA_W; i++)
		word_trunc[i] = fifo_data[i] && (i < int'(data_len));
end

always_comb
begin
	case (parity)
	PAR_EVEN:
		par_calc = ^word_trunc;
	PAR_ODD:
		par_calc = ~(^word_trunc);
	PAR_ZERO:
		par_calc = 1'b0;
	default:
		par_calc = 1'b1;
	endcase
end

always_ff @(posedge pe_clk)
begin
	if (fifo_re)
	begin
		word_q <= word_trunc;
		par_q <= par_calc;
	end
end

// one-cycle bits can ask for data 0 while the read is still on
assign word_src = fifo_re ? word_trunc : word_q;

// ==========================================================
// line drive, idle high with output disabled
// ==========================================================

always_ff @(posedge pe_clk or negedge pe_rstn)
begin
	if (!pe_rstn)
	begin
		uart_tx <= 1'b1;
		uart_tx_oen <= 1'b1;
	end
	else if (tx_clr || line_release)
	begin
		uart_tx <= 1'b1;
		uart_tx_oen <= 1'b1;
	end
	else if (bit_start)
	begin
		uart_tx_oen <= 1'b0;
		case (next_state)
		TX_START:
			uart_tx <= 1'b0;
		// lsb first
		TX_DATA:
			uart_tx <= word_src[next_idx];
		TX_PARITY:
			uart_tx <= par_q;
		// stop and interval
		default:
			uart_tx <= 1'b1;
		endcase
	end
end

endmodule

`default_nettype wire

// File: logic/uart_tx_pe.sv
/* uart tx protocol engine */
`default_nettype none

module uart_tx_pe
	import uart_tx_cfg_pkg::*, uart_tx_fsm_pkg::*;
(
	input wire pe_clk,
	input wire pe_rstn,
	// configuration, held during a run
	input wire clkdiv_t clkdiv,
	input wire os_t oversampling,
	input wire data_bits_t data_bits,
	input wire parity_en,
	input wire parity_mode_t parity,
	input wire stop_bits_t stop_bits,
	input wire interval_t interval_bits,
	// control
	input wire tx_enable,
	input wire tx_clr,
	// fifo side
	input wire tx_word_t fifo_data,
	input wire fifo_empty,
	output logic fifo_re,
	// pin
	output logic uart_tx,
	output logic uart_tx_oen,
	output logic tx_done
);

logic baud_run;
logic bit_end;
logic bit_start;
logic line_release;
tx_state_t next_state;
bit_idx_t next_idx;

// ==========================================================
// timing base
// ==========================================================

uart_tx_baud u_baud
(
	.pe_clk       (pe_clk),
	.pe_rstn      (pe_rstn),
	.baud_run     (baud_run),
	.clkdiv       (clkdiv),
	.oversampling (oversampling),
	.bit_end      (bit_end)
);

// ==========================================================
// frame control
// ==========================================================

uart_tx_ctrl u_ctrl
(
	.pe_clk        (pe_clk),
	.pe_rstn       (pe_rstn),
	.tx_enable     (tx_enable),
	.tx_clr        (tx_clr),
	.bit_end       (bit_end),
	.fifo_empty    (fifo_empty),
	.data_bits     (data_bits),
	.parity_en     (parity_en),
	.stop_bits     (stop_bits),
	.interval_bits (interval_bits),
	.baud_run      (baud_run),
	.fifo_re       (fifo_re),
	.bit_start     (bit_start),
	.next_state    (next_state),
	.next_idx      (next_idx),
	.line_release  (line_release),
	.tx_done       (tx_done)
);

// ==========================================================
// data path and pin
// ==========================================================

uart_tx_serializer u_ser
(
	.pe_clk       (pe_clk),
	.pe_rstn      (pe_rstn),
	.fifo_re      (fifo_re),
	.fifo_data    (fifo_data),
	.data_bits    (data_bits),
	.parity       (parity),
	.bit_start    (bit_start),
	.next_state   (next_state),
	.next_idx     (next_idx),
	.line_release (line_release),
	.tx_clr       (tx_clr),
	.uart_tx      (uart_tx),
	.uart_tx_oen  (uart_tx_oen)
);

endmodule

`default_nettype wire

// File: test/uart_tx_pe_tb.sv
/* uart tx engine testbench */
`default_nettype none

module uart_tx_pe_tb
	import uart_tx_cfg_pkg::*, uart_tx_fsm_pkg::*;
();

timeunit 1ns;
timeprecision 1ps;

// bit budget of all tests, widest bit is 6 cycles
localparam int TOTAL_BITS = 10 + 16 * 13 + 6 * 17 + 2 * 15 + 2 * 12;
localparam int MAX_T = 6;
localparam int CYCLE_LIMIT = 2 * TOTAL_BITS * MAX_T + 1000;

logic pe_clk;
logic pe_rstn;
clkdiv_t clkdiv;
os_t oversampling;
data_bits_t data_bits;
logic parity_en;
parity_mode_t parity;
stop_bits_t stop_bits;
interval_t interval_bits;
logic tx_enable;
logic tx_clr;
tx_word_t fifo_data = '0;
logic fifo_empty = 1'b1;
logic fifo_re;
logic uart_tx;
logic uart_tx_oen;
logic tx_done;

// fifo contents, read pointer advances on each consumed word
tx_word_t fifo_mem[$];
int rd_ptr = 0;
logic pop_pending = 1'b0;

int re_cnt = 0;
int done_cnt = 0;
int cycle_cnt = 0;
int check_cnt = 0;
int err_cnt = 0;
logic [31:0] lfsr = 32'hf3099bcc;

uart_tx_pe UUT
(
	.pe_clk        (pe_clk),
	.pe_rstn       (pe_rstn),
	.clkdiv        (clkdiv),
	.oversampling  (oversampling),
	.data_bits     (data_bits),
	.parity_en     (parity_en),
	.parity        (parity),
	.stop_bits     (stop_bits),
	.interval_bits (interval_bits),
	.tx_enable     (tx_enable),
	.tx_clr        (tx_clr),
	.fifo_data     (fifo_data),
	.fifo_empty    (fifo_empty),
	.fifo_re       (fifo_re),
	.uart_tx       (uart_tx),
	.uart_tx_oen   (uart_tx_oen),
	.tx_done       (tx_done)
);

// ==========================================================
// clock, fifo model, pulse counters, run limit
// ==========================================================

initial
begin
	pe_clk = 1'b0;
	forever #5 pe_clk = ~pe_clk;
end

always @(negedge pe_clk)
begin
	// word taken at the last rising edge leaves now
	if (pop_pending)
		rd_ptr++;
	pop_pending = fifo_re;
	if (fifo_re)
		re_cnt++;
	if (tx_done)
		done_cnt++;
	if (rd_ptr < fifo_mem.size())
	begin
		fifo_data = fifo_mem[rd_ptr];
		fifo_empty = 1'b0;
	end
	else
	begin
		fifo_data = '0;
		fifo_empty = 1'b1;
	end
end

always @(posedge pe_clk)
begin
	cycle_cnt++;
	if (cycle_cnt >= CYCLE_LIMIT)
	begin
		$display("timeout: run still going after %0d cycles", cycle_cnt);
		$display("*** TEST FAILED ***");
		$finish;
	end
end

// ==========================================================
// helpers
// ==========================================================

task automatic check_value(input string msg, input logic [31:0] exp, input logic [31:0] act);
	check_cnt++;
	if (act !== exp)
	begin
		err_cnt++;
		$display("Error at %0d ns: %s, expected %0h, got %0h", $time, msg, exp, act);
	end
endtask

// fibonacci lfsr, taps 32 22 2 1, one step per bit
function automatic tx_word_t rand_word();
	tx_word_t w;
	logic fb;
	int i;
	w = '0;
	for (i = 0; i < $bits(tx_word_t); i++)
	begin
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		w[i] = fb;
	end
	return w;
endfunction

// parity by counting ones
function automatic logic exp_parity(input tx_word_t w, input parity_mode_t m);
	int ones;
	int i;
	ones = 0;
	for (i = 0; i < $bits(tx_word_t); i++)
		ones += int'(w[i]);
	case (m)
	PAR_EVEN:
		return (ones % 2) == 1;
	PAR_ODD:
		return (ones % 2) == 0;
	PAR_ZERO:
		return 1'b0;
	default:
		return 1'b1;
	endcase
endfunction

task automatic check_idle_line(input string where);
	check_value({where, ": uart_tx"}, 1, 32'(uart_tx));
	check_value({where, ": uart_tx_oen"}, 1, 32'(uart_tx_oen));
	check_value({where, ": fifo_re"}, 0, 32'(fifo_re));
	check_value({where, ": tx_done"}, 0, 32'(tx_done));
endtask

// enable pulse, returns in the first cycle of the start bit
task automatic kick_run();
	@(negedge pe_clk);
	tx_enable = 1'b1;
	check_value("line high before start", 1, 32'(uart_tx));
	@(negedge pe_clk);
	tx_enable = 1'b0;
	check_value("start bit one cycle after enable", 0, 32'(uart_tx));
	check_value("oen low in start bit", 0, 32'(uart_tx_oen));
endtask

// line decoder
// gap counts the high cycles before the start edge
// every bit must hold its level for all t cycles
task automatic recv_frame(input int t, input int nbits, input logic has_par,
	output tx_word_t word, output logic par_bit, output int gap);
	int nb;
	int b;
	int c;
	logic first;
	logic mid;
	gap = 0;
	word = '0;
	par_bit = 1'b0;
	while (uart_tx !== 1'b0)
	begin
		@(negedge pe_clk);
		gap++;
	end
	nb = 1 + nbits + (has_par ? 1 : 0);
	for (b = 0; b < nb; b++)
	begin
		check_value("oen low in frame", 0, 32'(uart_tx_oen));
		first = uart_tx;
		mid = first;
		for (c = 1; c < t; c++)
		begin
			@(negedge pe_clk);
			if (c == t / 2)
				mid = uart_tx;
			check_value($sformatf("bit %0d level held", b), 32'(first), 32'(uart_tx));
		end
		if (b == 0)
			check_value("start bit low", 0, 32'(mid));
		else if (b <= nbits)
			word[b - 1] = mid;
		else
			par_bit = mid;
		@(negedge pe_clk);
	end
endtask

// entered in the first stop cycle of the last frame
task automatic check_release(input int t, input int stops, input int done0);
	int k;
	for (k = 0; k < stops * t; k++)
	begin
		check_value("stop bit high", 1, 32'(uart_tx));
		check_value("oen low in stop bit", 0, 32'(uart_tx_oen));
		check_value("no tx_done during run", 0, 32'(tx_done));
		@(negedge pe_clk);
	end
	check_value("line high at release", 1, 32'(uart_tx));
	check_value("oen high at release", 1, 32'(uart_tx_oen));
	check_value("tx_done not yet", 0, 32'(tx_done));
	@(negedge pe_clk);
	check_value("tx_done one cycle after release", 1, 32'(tx_done));
	@(negedge pe_clk);
	check_value("tx_done one cycle wide", 0, 32'(tx_done));
	check_value("one tx_done per run", 1, done_cnt - done0);
endtask

// one run of nframes random words, decoded and checked
task automatic run_frames(input int cdiv, input int osmp, input data_bits_t code,
	input logic pen, input parity_mode_t pmode, input stop_bits_t scode,
	input interval_t intv, input int nframes);
	tx_word_t sent[$];
	tx_word_t w;
	tx_word_t got;
	tx_word_t mask;
	logic par_bit;
	int gap;
	int t;
	int len;
	int stops;
	int re0;
	int done0;
	int f;
	t = ((cdiv == 0) ? 1 : cdiv) * ((osmp == 0) ? 1 : osmp);
	len = ((code >= 4'd7) && (code <= 4'd10)) ? int'(code) : 8;
	stops = (scode == 2'd0) ? 1 : int'(scode);
	mask = tx_word_t'((1 << len) - 1);
	clkdiv = clkdiv_t'(cdiv);
	oversampling = os_t'(osmp);
	data_bits = code;
	parity_en = pen;
	parity = pmode;
	stop_bits = scode;
	interval_bits = intv;
	for (f = 0; f < nframes; f++)
	begin
		w = rand_word();
		sent.push_back(w);
		fifo_mem.push_back(w);
	end
	re0 = re_cnt;
	done0 = done_cnt;
	kick_run();
	for (f = 0; f < nframes; f++)
	begin
		recv_frame(t, len, pen, got, par_bit, gap);
		check_value($sformatf("frame %0d data", f), 32'(sent[f] & mask), 32'(got));
		if (pen)
			check_value($sformatf("frame %0d parity", f),
				32'(exp_parity(sent[f] & mask, pmode)), 32'(par_bit));
		// stop plus interval bit times between frames
		if (f > 0)
			check_value($sformatf("gap before frame %0d", f),
				(stops + int'(intv)) * t, gap);
	end
	check_release(t, stops, done0);
	check_value("one fifo_re per frame", nframes, re_cnt - re0);
endtask

// ==========================================================
// directed tests
// ==========================================================

task automatic check_reset_state();
	@(negedge pe_clk);
	pe_rstn = 1'b0;
	repeat (5)
	begin
		@(negedge pe_clk);
		check_idle_line("in reset");
	end
	pe_rstn = 1'b1;
	repeat (5)
	begin
		@(negedge pe_clk);
		check_idle_line("idle after reset");
	end
endtask

// 8N1, 6 cycles per bit
task automatic send_basic_frame();
	run_frames(3, 2, 4'd8, 1'b0, PAR_EVEN, 2'd1, 4'd0, 1);
endtask

task automatic sweep_formats();
	data_bits_t codes[4];
	parity_mode_t modes[4];
	int c;
	int m;
	// code 12 falls back to 8 bits
	codes = '{4'd7, 4'd9, 4'd10, 4'd12};
	modes = '{PAR_EVEN, PAR_ODD, PAR_ZERO, PAR_ONE};
	for (c = 0; c < 4; c++)
		for (m = 0; m < 4; m++)
			run_frames(2, 2, codes[c], 1'b1, modes[m], 2'd1, 4'd0, 1);
endtask

task automatic send_multi_frame();
	run_frames(2, 2, 4'd8, 1'b0, PAR_EVEN, 2'd2, 4'd0, 3);
	run_frames(1, 4, 4'd8, 1'b1, PAR_EVEN, 2'd3, 4'd4, 3);
endtask

task automatic verify_run_end();
	int done0;
	run_frames(3, 2, 4'd8, 1'b1, PAR_ODD, 2'd2, 4'd3, 2);
	done0 = done_cnt;
	repeat (12)
	begin
		@(negedge pe_clk);
		check_idle_line("idle after run");
	end
	check_value("no tx_done while idle", done0, done_cnt);
endtask

task automatic abort_and_restart();
	tx_word_t w;
	int done0;
	clkdiv = clkdiv_t'(2);
	oversampling = os_t'(2);
	data_bits = 4'd8;
	parity_en = 1'b0;
	parity = PAR_EVEN;
	stop_bits = 2'd1;
	interval_bits = 4'd0;
	w = rand_word();
	fifo_mem.push_back(w);
	done0 = done_cnt;
	kick_run();
	// middle of data bit 2
	repeat (14) @(negedge pe_clk);
	tx_clr = 1'b1;
	@(negedge pe_clk);
	tx_clr = 1'b0;
	@(negedge pe_clk);
	check_value("line high after clear", 1, 32'(uart_tx));
	check_value("oen high after clear", 1, 32'(uart_tx_oen));
	repeat (16)
	begin
		@(negedge pe_clk);
		check_idle_line("idle after clear");
	end
	check_value("no tx_done after clear", done0, done_cnt);
	// fresh run must decode
	run_frames(2, 2, 4'd8, 1'b0, PAR_EVEN, 2'd1, 4'd0, 1);
endtask

// ==========================================================
// main sequence
// ==========================================================

initial
begin
	pe_rstn = 1'b1;
	clkdiv = clkdiv_t'(1);
	oversampling = os_t'(1);
	data_bits = 4'd8;
	parity_en = 1'b0;
	parity = PAR_EVEN;
	stop_bits = 2'd0;
	interval_bits = 4'd0;
	tx_enable = 1'b0;
	tx_clr = 1'b0;

	check_reset_state();
	send_basic_frame();
	sweep_formats();
	send_multi_frame();
	verify_run_end();
	abort_and_restart();

	$display("checks: %0d, errors: %0d", check_cnt, err_cnt);
	if (err_cnt == 0)
		$display("*** TEST PASSED ***");
	else
		$display("*** TEST FAILED ***");
	$finish;
end

endmodule

`default_nettype wire

// File: uart_tx_pe.f
+incdir+logic
logic/uart_tx_cfg_pkg.sv
logic/uart_tx_fsm_pkg.sv
logic/uart_tx_baud.sv
logic/uart_tx_ctrl.sv
logic/uart_tx_serializer.sv
logic/uart_tx_pe.sv
test/uart_tx_pe_tb.sv

// File: Makefile
TOP = uart_tx_pe_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f uart_tx_pe.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
